/* list.f */
rtl/sdr_link_pkg.sv
rtl/sdr_ctrl_pkg.sv
rtl/sdr_link_ctrl.sv
rtl/sdr_token_credit.sv
rtl/sdr_uplink.sv
rtl/sdr_downlink.sv
rtl/sdr_link_edge.sv
verification/sdr_link_edge_chk.sv
verification/sdr_link_edge_tb.sv

/* Makefile */
TOP := sdr_link_edge_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -f list.f \
	  --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* verification/sdr_link_edge_tb.sv */
// Testbench for the SDR link edge
//
// Brings the link up over APB, pushes random packets through both data
// paths, returns tokens by hand and compares every packet, credit count
// and token count with a small reference model.

module sdr_link_edge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int lg_depth_c = 3;
  localparam int lg_dec_c   = 1;
  localparam int depth_c    = 1 << lg_depth_c;
  localparam int timeout_c  = 200;
  localparam int n_up_c     = 12;
  localparam int n_dn_c     = 20;

  // counter selectors for wait_count
  localparam int sel_io_c  = 0;
  localparam int sel_dn_c  = 1;
  localparam int sel_tok_c = 2;

  logic clk, rst_n, core_reset, core_ready_o, core_v_o, io_v_o, io_token_o;
  logic core_v_i, core_ready_i, io_token_i, io_v_i;
  sdr_ctrl_pkg::apb_req_t  apb_req;
  sdr_ctrl_pkg::apb_rsp_t  apb_rsp;
  sdr_link_pkg::link_pkt_t core_pkt_i, core_pkt_o, io_pkt_o, io_pkt_i;

  sdr_link_pkg::link_pkt_t up_exp[$];
  sdr_link_pkg::link_pkt_t dn_exp[$];
  int io_sent, consumed, tokens_seen, dn_sent, mismatch_cnt, fail_cnt;
  logic [31:0] rnd;

  sdr_link_edge #(
    .lg_fifo_depth_p                  (lg_depth_c)
    ,.lg_credit_to_token_decimation_p (lg_dec_c)
    ,.reset_wait_p                    (4)
  ) u_dut (
    .core_clk_i     (clk)
    ,.rst_n_i       (rst_n)
    ,.apb_req_i     (apb_req)
    ,.apb_rsp_o     (apb_rsp)
    ,.core_reset_o  (core_reset)
    ,.core_pkt_i    (core_pkt_i)
    ,.core_v_i      (core_v_i)
    ,.core_ready_o  (core_ready_o)
    ,.core_pkt_o    (core_pkt_o)
    ,.core_v_o      (core_v_o)
    ,.core_ready_i  (core_ready_i)
    ,.io_pkt_o      (io_pkt_o)
    ,.io_v_o        (io_v_o)
    ,.io_token_i    (io_token_i)
    ,.io_pkt_i      (io_pkt_i)
    ,.io_v_i        (io_v_i)
    ,.io_token_o    (io_token_o)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // credits left on a link after sent packets and returned tokens
  function automatic int exp_credit(input int sent, input int tokens);
    return depth_c - sent + tokens * (1 << lg_dec_c);
  endfunction

  function automatic int exp_tokens(input int n_consumed);
    return n_consumed / (1 << lg_dec_c);
  endfunction

  function automatic int count_of(input int sel);
    case (sel)
      sel_io_c: return io_sent;
      sel_dn_c: return consumed;
      default:  return tokens_seen;
    endcase
  endfunction

  task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic wait_count(input int sel, input int target, input string what);
    int t;
    t = 0;
    while (count_of(sel) < target && t < timeout_c) begin
      @(negedge clk);
      t++;
    end
    if (count_of(sel) < target) begin
      fail_cnt++;
      $display("timed out waiting for %s", what);
    end
  endtask

  task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int t;
    apb_req.paddr   = addr;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    t = 0;
    @(posedge clk);
    while (!apb_rsp.pready && t < timeout_c) begin
      @(posedge clk);
      t++;
    end
    if (!apb_rsp.pready) begin
      fail_cnt++;
      $display("APB access to address %0h never completed", addr);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic read_status(output logic [2:0] st, output logic [7:0] cr);
    logic [31:0] rd;
    logic err;
    apb_access(sdr_ctrl_pkg::status_addr_c, 1'b0, 32'h0, rd, err);
    check("STATUS pslverr", err, 0);
    st = rd[2:0];
    cr = rd[15:8];
  endtask

  task automatic write_ctrl(input logic [31:0] data);
    logic [31:0] rd;
    logic err;
    apb_access(sdr_ctrl_pkg::ctrl_addr_c, 1'b1, data, rd, err);
    check("CTRL pslverr", err, 0);
  endtask

  task automatic wait_link_up();
    int t;
    logic [2:0] st;
    logic [7:0] cr;
    t  = 0;
    st = '0;
    while (st != sdr_ctrl_pkg::link_up && t < 40) begin
      read_status(st, cr);
      t++;
    end
    if (st != sdr_ctrl_pkg::link_up) begin
      fail_cnt++;
      $display("timed out waiting for the link to come up");
    end
  endtask

  task automatic rand_pkt(output sdr_link_pkg::link_pkt_t p);
    rnd      = lcg_step(rnd);
    p.opcode = rnd[1:0];
    p.addr   = rnd[31:4];
    rnd      = lcg_step(rnd);
    p.data   = rnd;
    rnd      = lcg_step(rnd);
    p.dest_x = rnd[22:16];
    p.dest_y = rnd[14:8];
  endtask

  task automatic send_up(input sdr_link_pkg::link_pkt_t p);
    int t;
    core_pkt_i = p;
    core_v_i   = 1'b1;
    t = 0;
    while (!core_ready_o && t < timeout_c) begin
      @(negedge clk);
      t++;
    end
    if (!core_ready_o) begin
      fail_cnt++;
      $display("uplink never accepted a packet from the core");
    end else begin
      up_exp.push_back(p);
    end
    @(negedge clk);
    core_v_i = 1'b0;
  endtask

  task automatic pulse_token();
    io_token_i = 1'b1;
    @(negedge clk);
    io_token_i = 1'b0;
  endtask

  // response side, sampled on the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (io_v_o) begin
        io_sent++;
        if (up_exp.size() == 0) begin
          fail_cnt++;
          $display("packet on the io link with none outstanding at %0t", $time);
        end else begin
          check("io_pkt_o", io_pkt_o, up_exp.pop_front());
        end
      end
      if (core_v_o && core_ready_i) begin
        consumed++;
        if (dn_exp.size() == 0) begin
          fail_cnt++;
          $display("packet to the core with none outstanding at %0t", $time);
        end else begin
          check("core_pkt_o", core_pkt_o, dn_exp.pop_front());
        end
      end
      if (io_token_o) begin
        tokens_seen++;
      end
    end
  end

  initial begin
    sdr_link_pkg::link_pkt_t p;
    logic [2:0]  st;
    logic [7:0]  cr;
    logic [31:0] rd;
    logic        err;
    int          t;
    clk = 1'b0;
    rst_n = 1'b0;
    apb_req = '0;
    core_pkt_i = '0;
    core_v_i = 1'b0;
    core_ready_i = 1'b0;
    io_token_i = 1'b0;
    io_pkt_i = '0;
    io_v_i = 1'b0;
    rnd = 32'hf67e;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // idle after reset, every link output quiet
    read_status(st, cr);
    check("state after reset", st, sdr_ctrl_pkg::idle);
    check("credit after reset", cr, depth_c);
    check("core_reset_o after reset", core_reset, 1);
    check("link outputs after reset", {core_ready_o, core_v_o, io_v_o, io_token_o}, 0);

    write_ctrl(32'h1);
    wait_link_up();
    check("core_reset_o at link up", core_reset, 0);
    read_status(st, cr);
    check("credit at link up", cr, exp_credit(0, 0));
    apb_access(8'h10, 1'b0, 32'h0, rd, err);
    check("pslverr on unknown address", err, 1);
    check("read data on unknown address", rd, 0);

    // no tokens yet, so only depth_c packets may leave
    for (int i = 0; i < n_up_c; i++) begin
      rand_pkt(p);
      send_up(p);
      repeat (rnd[9:8]) @(negedge clk);
    end
    wait_count(sel_io_c, depth_c, "the first burst on the io link");
    repeat (20) @(negedge clk);
    check("packets sent without tokens", io_sent, depth_c);

    for (int k = 1; k <= 3; k++) begin
      pulse_token();
      if (k < 3) begin
        wait_count(sel_io_c, depth_c + k * (1 << lg_dec_c), "packets released by a token");
      end
    end
    repeat (10) @(negedge clk);
    check("packets sent after tokens", io_sent, n_up_c);
    check("uplink packets left over", up_exp.size(), 0);
    read_status(st, cr);
    check("credit after uplink traffic", cr, exp_credit(n_up_c, 3));

    // far side keeps within its credits, core stalls at random
    for (int i = 0; i < n_dn_c; i++) begin
      t = 0;
      while (exp_credit(dn_sent, tokens_seen) <= 0 && t < timeout_c) begin
        rnd = lcg_step(rnd);
        core_ready_i = (rnd[17:16] != 2'b00);
        @(negedge clk);
        t++;
      end
      if (exp_credit(dn_sent, tokens_seen) <= 0) begin
        fail_cnt++;
        $display("timed out waiting for downlink tokens");
      end
      rand_pkt(p);
      io_pkt_i = p;
      io_v_i = 1'b1;
      dn_exp.push_back(p);
      dn_sent++;
      rnd = lcg_step(rnd);
      core_ready_i = (rnd[17:16] != 2'b00);
      @(negedge clk);
      io_v_i = 1'b0;
    end
    t = 0;
    while (consumed < n_dn_c && t < timeout_c) begin
      rnd = lcg_step(rnd);
      core_ready_i = (rnd[17:16] != 2'b00);
      @(negedge clk);
      t++;
    end
    core_ready_i = 1'b0;
    if (consumed < n_dn_c) begin
      fail_cnt++;
      $display("timed out waiting for the core to drain the downlink");
    end
    wait_count(sel_tok_c, exp_tokens(n_dn_c), "downlink tokens");
    repeat (4) @(negedge clk);
    check("tokens returned", tokens_seen, exp_tokens(n_dn_c));
    check("downlink packets left over", dn_exp.size(), 0);

    // stop, then bring the link back with full credit
    write_ctrl(32'h2);
    read_status(st, cr);
    check("state after stop", st, sdr_ctrl_pkg::idle);
    check("core_reset_o after stop", core_reset, 1);
    write_ctrl(32'h1);
    wait_link_up();
    read_status(st, cr);
    check("credit after restart", cr, exp_credit(0, 0));
    check("core_reset_o after restart", core_reset, 0);

    $display("error counts: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_cnt, fail_cnt, u_dut.u_chk.assert_fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0 && u_dut.u_chk.assert_fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verification/sdr_link_edge_chk.sv */
// Link edge protocol checks
//
// Concurrent assertions bound into the link edge top level. They watch
// the IO uplink during core reset, the token pulse width and the APB
// access cycle.

module sdr_link_edge_chk (
  input                             core_clk_i
  , input                           rst_n_i
  , input sdr_ctrl_pkg::apb_req_t   apb_req_i
  , input sdr_ctrl_pkg::apb_rsp_t   apb_rsp_i
  , input                           core_reset_i
  , input                           link_v_i
  , input                           token_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions so far
  int assert_fail_cnt = 0;

  // nothing leaves on the io link while the core is held
  no_send_in_reset_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    core_reset_i |-> !link_v_i)
    else begin
      assert_fail_cnt++;
      $error("io_v_o was high while core_reset_o was set");
    end

  token_pulse_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    token_i |=> !token_i)
    else begin
      assert_fail_cnt++;
      $error("io_token_o stayed high for more than one cycle");
    end

  // zero wait state slave
  apb_ready_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_i.pready)
    else begin
      assert_fail_cnt++;
      $error("pready was low in an APB access cycle");
    end

endmodule

bind sdr_link_edge sdr_link_edge_chk u_chk (
  .core_clk_i     (core_clk_i)
  ,.rst_n_i       (rst_n_i)
  ,.apb_req_i     (apb_req_i)
  ,.apb_rsp_i     (apb_rsp_o)
  ,.core_reset_i  (core_reset_o)
  ,.link_v_i      (io_v_o)
  ,.token_i       (io_token_o)
);

/* rtl/sdr_link_edge.sv */
// Manycore SDR link edge
//
// Single clock endpoint between the core forward network and an IO link
// with token flow control. Ties together the APB control block, the
// uplink credit counter and the two packet paths.

module sdr_link_edge
  #(parameter int lg_fifo_depth_p                   = 3
    , parameter int lg_credit_to_token_decimation_p = 1
    , parameter int reset_wait_p                    = 4
  )
  (
    input                                core_clk_i
    , input                              rst_n_i

    , input  sdr_ctrl_pkg::apb_req_t     apb_req_i
    , output sdr_ctrl_pkg::apb_rsp_t     apb_rsp_o
    , output logic                       core_reset_o

    // core side
    , input  sdr_link_pkg::link_pkt_t    core_pkt_i
    , input                              core_v_i
    , output logic                       core_ready_o

    , output sdr_link_pkg::link_pkt_t    core_pkt_o
    , output logic                       core_v_o
    , input                              core_ready_i

    // io side
    , output sdr_link_pkg::link_pkt_t    io_pkt_o
    , output logic                       io_v_o
    , input                              io_token_i

    , input  sdr_link_pkg::link_pkt_t    io_pkt_i
    , input                              io_v_i
    , output logic                       io_token_o
  );

  sdr_ctrl_pkg::link_rst_t link_rst;
  logic       spend;
  logic       credit_avail;
  logic [7:0] credit_count;

  sdr_link_ctrl #(
    .reset_wait_p     (reset_wait_p)
  ) u_ctrl (
    .core_clk_i       (core_clk_i)
    ,.rst_n_i         (rst_n_i)
    ,.apb_req_i       (apb_req_i)
    ,.apb_rsp_o       (apb_rsp_o)
    ,.credit_count_i  (credit_count)
    ,.link_rst_o      (link_rst)
    ,.core_reset_o    (core_reset_o)
  );

  sdr_token_credit #(
    .lg_fifo_depth_p                  (lg_fifo_depth_p)
    ,.lg_credit_to_token_decimation_p (lg_credit_to_token_decimation_p)
  ) u_credit (
    .core_clk_i       (core_clk_i)
    ,.rst_n_i         (rst_n_i)
    ,.link_rst_i      (link_rst)
    ,.spend_i         (spend)
    ,.token_i         (io_token_i)
    ,.credit_avail_o  (credit_avail)
    ,.credit_count_o  (credit_count)
  );

  sdr_uplink #(
    .lg_fifo_depth_p  (lg_fifo_depth_p)
  ) u_uplink (
    .core_clk_i       (core_clk_i)
    ,.rst_n_i         (rst_n_i)
    ,.link_rst_i      (link_rst)
    ,.core_pkt_i      (core_pkt_i)
    ,.core_v_i        (core_v_i)
    ,.core_ready_o    (core_ready_o)
    ,.credit_avail_i  (credit_avail)
    ,.io_pkt_o        (io_pkt_o)
    ,.io_v_o          (io_v_o)
    ,.spend_o         (spend)
  );

  sdr_downlink #(
    .lg_fifo_depth_p                  (lg_fifo_depth_p)
    ,.lg_credit_to_token_decimation_p (lg_credit_to_token_decimation_p)
  ) u_downlink (
    .core_clk_i       (core_clk_i)
    ,.rst_n_i         (rst_n_i)
    ,.link_rst_i      (link_rst)
    ,.io_pkt_i        (io_pkt_i)
    ,.io_v_i          (io_v_i)
    ,.io_token_o      (io_token_o)
    ,.core_pkt_o      (core_pkt_o)
    ,.core_v_o        (core_v_o)
    ,.core_ready_i    (core_ready_i)
  );

endmodule

/* rtl/sdr_downlink.sv */
// IO to core downlink
//
// Receive FIFO for packets from the IO link, presented to the core with
// ready/valid. Every 2^decimation packets the core consumes, one token
// goes back to the far side to return that many credits.

module sdr_downlink
  #(parameter int lg_fifo_depth_p                   = 3
    , parameter int lg_credit_to_token_decimation_p = 1
  )
  (
    input                                core_clk_i
    , input                              rst_n_i
    , input  sdr_ctrl_pkg::link_rst_t    link_rst_i

    , input  sdr_link_pkg::link_pkt_t    io_pkt_i
    , input                              io_v_i
    , output logic                       io_token_o

    , output sdr_link_pkg::link_pkt_t    core_pkt_o
    , output logic                       core_v_o
    , input                              core_ready_i
  );

  localparam int depth_lp     = 1 << lg_fifo_depth_p;
  localparam int dec_width_lp = lg_credit_to_token_decimation_p + 1;

  localparam logic [dec_width_lp-1:0] dec_last_lp =
    dec_width_lp'((1 << lg_credit_to_token_decimation_p) - 1);

  sdr_link_pkg::link_pkt_t mem_r [depth_lp];

  logic [lg_fifo_depth_p:0] wr_ptr_r, rd_ptr_r;
  logic [dec_width_lp-1:0]  dec_cnt_r;
  logic empty_w, push_w, pop_w, wrap_w, token_r;

  // far side never sends past its credits, so no full check
  assign empty_w = (wr_ptr_r == rd_ptr_r);
  assign push_w  = io_v_i & ~link_rst_i.downlink;

  assign core_pkt_o = mem_r[rd_ptr_r[lg_fifo_depth_p-1:0]];
  assign core_v_o   = ~empty_w & ~link_rst_i.downstream;
  assign pop_w      = core_v_o & core_ready_i;

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i || link_rst_i.downlink) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      wr_ptr_r <= wr_ptr_r + push_w;
      rd_ptr_r <= rd_ptr_r + pop_w;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (push_w) begin
      mem_r[wr_ptr_r[lg_fifo_depth_p-1:0]] <= io_pkt_i;
    end
  end

  // consumed packet count, token on each wrap
  assign wrap_w = pop_w & (dec_cnt_r == dec_last_lp);

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i || link_rst_i.token) begin
      dec_cnt_r <= '0;
      token_r   <= 1'b0;
    end else begin
      token_r <= wrap_w;
      if (wrap_w) begin
        dec_cnt_r <= '0;
      end else if (pop_w) begin
        dec_cnt_r <= dec_cnt_r + 1'b1;
      end
    end
  end

  assign io_token_o = token_r;

endmodule

/* rtl/sdr_uplink.sv */
// Core to IO uplink
//
// Circular packet FIFO between the core and the IO link. The head is
// registered onto the link whenever a credit is available, and the
// same transfer spends one credit.

module sdr_uplink
  #(parameter int lg_fifo_depth_p = 3)
  (
    input                                core_clk_i
    , input                              rst_n_i
    , input  sdr_ctrl_pkg::link_rst_t    link_rst_i

    , input  sdr_link_pkg::link_pkt_t    core_pkt_i
    , input                              core_v_i
    , output logic                       core_ready_o

    , input                              credit_avail_i
    , output sdr_link_pkg::link_pkt_t    io_pkt_o
    , output logic                       io_v_o
    , output logic                       spend_o
  );

  localparam int depth_lp = 1 << lg_fifo_depth_p;

  sdr_link_pkg::link_pkt_t mem_r [depth_lp];
  sdr_link_pkg::link_pkt_t io_pkt_r;

  // extra msb tells full from empty
  logic [lg_fifo_depth_p:0] wr_ptr_r, rd_ptr_r;
  logic full_w, empty_w, push_w, send_w, io_v_r;

  assign empty_w = (wr_ptr_r == rd_ptr_r);
  assign full_w  = (wr_ptr_r[lg_fifo_depth_p] != rd_ptr_r[lg_fifo_depth_p])
                 & (wr_ptr_r[lg_fifo_depth_p-1:0] == rd_ptr_r[lg_fifo_depth_p-1:0]);

  assign core_ready_o = ~full_w & ~link_rst_i.uplink;
  assign push_w       = core_v_i & core_ready_o;
  assign send_w       = ~empty_w & credit_avail_i & ~link_rst_i.uplink;

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i || link_rst_i.uplink) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      io_v_r   <= 1'b0;
    end else begin
      wr_ptr_r <= wr_ptr_r + push_w;
      rd_ptr_r <= rd_ptr_r + send_w;
      io_v_r   <= send_w;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (push_w) begin
      mem_r[wr_ptr_r[lg_fifo_depth_p-1:0]] <= core_pkt_i;
    end
    if (send_w) begin
      io_pkt_r <= mem_r[rd_ptr_r[lg_fifo_depth_p-1:0]];
    end
  end

  // a packet in flight when the link drops is discarded
  assign io_v_o   = io_v_r & ~link_rst_i.uplink;
  assign io_pkt_o = io_pkt_r;
  assign spend_o  = send_w;

endmodule

/* rtl/sdr_token_credit.sv */
// Uplink credit counter
//
// Holds the number of packets the far side can still accept. Loaded with
// the full FIFO depth under the token reset, one credit spent per packet
// sent, and 2^decimation credits added per returned token.

module sdr_token_credit
  #(parameter int lg_fifo_depth_p                   = 3
    , parameter int lg_credit_to_token_decimation_p = 1
  )
  (
    input                               core_clk_i
    , input                             rst_n_i
    , input  sdr_ctrl_pkg::link_rst_t   link_rst_i

    , input                             spend_i
    , input                             token_i

    , output logic                      credit_avail_o
    , output logic [7:0]                credit_count_o
  );

  localparam int credit_width_lp = lg_fifo_depth_p + 1;

  localparam logic [credit_width_lp-1:0] full_credits_lp  =
    credit_width_lp'(1 << lg_fifo_depth_p);
  localparam logic [credit_width_lp-1:0] token_credits_lp =
    credit_width_lp'(1 << lg_credit_to_token_decimation_p);

  logic [credit_width_lp-1:0] count_r;
  logic [credit_width_lp-1:0] refill_w;

  assign refill_w = token_i ? token_credits_lp : '0;

  // tokens only ever return credits already spent
  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i || link_rst_i.token) begin
      count_r <= full_credits_lp;
    end else begin
      count_r <= count_r - credit_width_lp'(spend_i) + refill_w;
    end
  end

  assign credit_avail_o = (count_r != '0);
  assign credit_count_o = 8'(count_r);

endmodule

/* rtl/sdr_link_ctrl.sv */
// Link control and reset sequencer
//
// APB slave with a CTRL command register and a STATUS register. A start
// command steps through the uplink, downlink, downstream and token resets,
// each held for reset_wait_p cycles, then releases the core reset.
// A stop command returns to idle with every reset asserted.

module sdr_link_ctrl
  #(parameter int reset_wait_p = 4)
  (
    input                               core_clk_i
    , input                             rst_n_i

    , input  sdr_ctrl_pkg::apb_req_t    apb_req_i
    , output sdr_ctrl_pkg::apb_rsp_t    apb_rsp_o

    , input  [7:0]                      credit_count_i

    , output sdr_ctrl_pkg::link_rst_t   link_rst_o
    , output logic                      core_reset_o
  );

  localparam int wait_width_lp = $clog2(reset_wait_p + 1);

  sdr_ctrl_pkg::seq_state_e   state_r;
  sdr_ctrl_pkg::link_rst_t    link_rst_r;
  logic [wait_width_lp-1:0]   wait_cnt_r;
  logic                       core_reset_r;

  logic access_w, ctrl_hit_w, status_hit_w, ctrl_wr_w;
  logic start_w, stop_w, in_phase_w, wait_done_w;

  assign access_w     = apb_req_i.psel & apb_req_i.penable;
  assign ctrl_hit_w   = (apb_req_i.paddr == sdr_ctrl_pkg::ctrl_addr_c);
  assign status_hit_w = (apb_req_i.paddr == sdr_ctrl_pkg::status_addr_c);
  assign ctrl_wr_w    = access_w & apb_req_i.pwrite & ctrl_hit_w;

  assign start_w = ctrl_wr_w & apb_req_i.pwdata[0] & (state_r == sdr_ctrl_pkg::idle);
  assign stop_w  = ctrl_wr_w & apb_req_i.pwdata[1];

  assign in_phase_w  = state_r inside {sdr_ctrl_pkg::uplink_rst, sdr_ctrl_pkg::downlink_rst,
                                       sdr_ctrl_pkg::downstream_rst, sdr_ctrl_pkg::token_rst};
  assign wait_done_w = in_phase_w & (wait_cnt_r == wait_width_lp'(reset_wait_p - 1));

  // zero wait states, status only readable register
  always_comb begin
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = access_w & ~(ctrl_hit_w | status_hit_w);
    apb_rsp_o.prdata  = status_hit_w ? {16'h0, credit_count_i, 5'h0, state_r} : 32'h0;
  end

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i || stop_w) begin
      state_r      <= sdr_ctrl_pkg::idle;
      link_rst_r   <= '1;
      core_reset_r <= 1'b1;
      wait_cnt_r   <= '0;
    end else begin
      wait_cnt_r <= (in_phase_w && !wait_done_w) ? wait_cnt_r + 1'b1 : '0;
      case (state_r)
        sdr_ctrl_pkg::idle: begin
          if (start_w) begin
            state_r <= sdr_ctrl_pkg::uplink_rst;
          end
        end
        sdr_ctrl_pkg::uplink_rst: begin
          if (wait_done_w) begin
            link_rst_r.uplink <= 1'b0;
            state_r           <= sdr_ctrl_pkg::downlink_rst;
          end
        end
        sdr_ctrl_pkg::downlink_rst: begin
          if (wait_done_w) begin
            link_rst_r.downlink <= 1'b0;
            state_r             <= sdr_ctrl_pkg::downstream_rst;
          end
        end
        sdr_ctrl_pkg::downstream_rst: begin
          if (wait_done_w) begin
            link_rst_r.downstream <= 1'b0;
            state_r               <= sdr_ctrl_pkg::token_rst;
          end
        end
        sdr_ctrl_pkg::token_rst: begin
          // last phase, core comes out of reset with the link
          if (wait_done_w) begin
            link_rst_r.token <= 1'b0;
            core_reset_r     <= 1'b0;
            state_r          <= sdr_ctrl_pkg::link_up;
          end
        end
        default: begin
          state_r <= state_r;
        end
      endcase
    end
  end

  assign link_rst_o   = link_rst_r;
  assign core_reset_o = core_reset_r;

endmodule

/* rtl/sdr_ctrl_pkg.sv */
// Link edge control definitions
//
// APB request and response structs, register offsets, reset sequencer
// state codes and the bundle of four link resets.

package sdr_ctrl_pkg;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // register offsets
  localparam logic [7:0] ctrl_addr_c   = 8'h00;
  localparam logic [7:0] status_addr_c = 8'h04;

  // sequencer states, visible in STATUS[2:0]
  typedef enum logic [2:0] {
    idle           = 3'd0,
    uplink_rst     = 3'd1,
    downlink_rst   = 3'd2,
    downstream_rst = 3'd3,
    token_rst      = 3'd4,
    link_up        = 3'd5
  } seq_state_e;

  // active high link resets, released in this order
  typedef struct packed {
    logic uplink;
    logic downlink;
    logic downstream;
    logic token;
  } link_rst_t;

endpackage

/* rtl/sdr_link_pkg.sv */
// Manycore forward link definitions
//
// Field widths and the packet struct carried by the forward network
// between the core side and the off-array IO link. The same struct
// travels in both directions.

package sdr_link_pkg;

  // packet field widths
  localparam int op_width_c     = 2;
  localparam int addr_width_c   = 28;
  localparam int data_width_c   = 32;
  localparam int x_cord_width_c = 7;
  localparam int y_cord_width_c = 7;

  // one forward packet, opcode in the top bits
  typedef struct packed {
    logic [op_width_c-1:0]     opcode;
    logic [addr_width_c-1:0]   addr;
    logic [data_width_c-1:0]   data;
    logic [x_cord_width_c-1:0] dest_x;
    logic [y_cord_width_c-1:0] dest_y;
  } link_pkt_t;

  // 76 bits with the widths above
  localparam int link_pkt_width_c = op_width_c + addr_width_c + data_width_c
                                  + x_cord_width_c + y_cord_width_c;

endpackage
